// File: Makefile
VERILATOR ?= verilator
TOP       ?= pulse_gen_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
pulse_pkg.sv
pulse_cfg_if.sv
gen_pulse_reg.sv
pulse_sequencer.sv
pulse_output.sv
pulse_gen_top.sv
pulse_gen_tb.sv

// File: gen_pulse_reg.sv
`timescale 1ns/100ps

module gen_pulse_reg #(
    parameter int ADDR_WIDTH = 16,
    parameter int CNT_WIDTH  = 24
) (
    input  logic                  clk,
    input  logic                  reset,

    // wishbone slave
    input  logic [ADDR_WIDTH-1:0] wbs_address,
    input  pulse_pkg::wb_data_t   wbs_writedata,
    output pulse_pkg::wb_data_t   wbs_readdata,
    input  logic                  wbs_strobe,
    input  logic                  wbs_cycle,
    input  logic                  wbs_write,
    output logic                  wbs_ack,

    // status from the datapath
    input  logic                  busy,
    input  logic                  cfg_error,
    input  logic [CNT_WIDTH-1:0]  pulse_count,

    pulse_cfg_if.regs             cfg
);

    localparam int DW = $bits(pulse_pkg::wb_data_t);

    // ------------------------------------------------------------
    // bus handshake
    // ------------------------------------------------------------
    logic trans;
    logic ack_q;
    logic write;
    logic read;

    assign trans   = wbs_strobe & wbs_cycle;
    // registered ack, dropped at once if the master gives up
    assign wbs_ack = ack_q & trans;
    // store on the first edge of the access only
    assign write   = trans & wbs_write & ~ack_q;
    assign read    = trans & ~wbs_write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            // one ack per access, even if strobe is held
            ack_q <= trans & ~ack_q;
        end
    end

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------
    logic [7:0] addr;
    logic       period_sel, width_sel, ctrl_sel, status_sel, count_sel;

    assign addr       = wbs_address[7:0];
    assign period_sel = (addr == pulse_pkg::REG_PERIOD_ADDR);
    assign width_sel  = (addr == pulse_pkg::REG_WIDTH_ADDR);
    assign ctrl_sel   = (addr == pulse_pkg::REG_CTRL_ADDR);
    assign status_sel = (addr == pulse_pkg::REG_STATUS_ADDR);
    assign count_sel  = (addr == pulse_pkg::REG_COUNT_ADDR);

    // ------------------------------------------------------------
    // writable registers
    // ------------------------------------------------------------
    logic [CNT_WIDTH-1:0]   period_reg;
    logic [CNT_WIDTH-1:0]   width_reg;
    pulse_pkg::pulse_mode_t mode_reg;
    logic                   pol_reg;
    pulse_pkg::burst_len_t  burst_reg;
    logic                   ctrl_write_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            period_reg   <= '0;
            width_reg    <= '0;
            mode_reg     <= pulse_pkg::MODE_OFF;
            pol_reg      <= 1'b0;
            burst_reg    <= '0;
            ctrl_write_q <= 1'b0;
        end else begin
            ctrl_write_q <= write & ctrl_sel;
            // timing registers keep the low CNT_WIDTH bits
            if (write & period_sel) begin
                period_reg <= wbs_writedata[CNT_WIDTH-1:0];
            end
            if (write & width_sel) begin
                width_reg <= wbs_writedata[CNT_WIDTH-1:0];
            end
            if (write & ctrl_sel) begin
                mode_reg  <= pulse_pkg::pulse_mode_t'(
                    wbs_writedata[pulse_pkg::CTRL_MODE_MSB:pulse_pkg::CTRL_MODE_LSB]);
                pol_reg   <= wbs_writedata[pulse_pkg::CTRL_POL_BIT];
                burst_reg <= wbs_writedata[pulse_pkg::CTRL_BURST_MSB:pulse_pkg::CTRL_BURST_LSB];
            end
        end
    end

    assign cfg.period     = period_reg;
    assign cfg.width      = width_reg;
    assign cfg.mode       = mode_reg;
    assign cfg.polarity   = pol_reg;
    assign cfg.burst_len  = burst_reg;
    assign cfg.ctrl_write = ctrl_write_q;

    // ------------------------------------------------------------
    // read path
    // ------------------------------------------------------------
    pulse_pkg::wb_data_t ctrl_word;
    pulse_pkg::wb_data_t status_word;

    // undefined control bits read back as zero
    always_comb begin
        ctrl_word = '0;
        ctrl_word[pulse_pkg::CTRL_MODE_MSB:pulse_pkg::CTRL_MODE_LSB]   = mode_reg;
        ctrl_word[pulse_pkg::CTRL_POL_BIT]                             = pol_reg;
        ctrl_word[pulse_pkg::CTRL_BURST_MSB:pulse_pkg::CTRL_BURST_LSB] = burst_reg;
    end

    always_comb begin
        status_word = '0;
        status_word[pulse_pkg::STAT_BUSY_BIT] = busy;
        status_word[pulse_pkg::STAT_ERR_BIT]  = cfg_error;
    end

    // each source masked by its own select
    pulse_pkg::wb_data_t period_rd, width_rd, ctrl_rd, status_rd, count_rd;

    assign period_rd = pulse_pkg::wb_data_t'(period_reg)  & {DW{period_sel & read}};
    assign width_rd  = pulse_pkg::wb_data_t'(width_reg)   & {DW{width_sel & read}};
    assign ctrl_rd   = ctrl_word                          & {DW{ctrl_sel & read}};
    assign status_rd = status_word                        & {DW{status_sel & read}};
    assign count_rd  = pulse_pkg::wb_data_t'(pulse_count) & {DW{count_sel & read}};

    // unmapped address falls through as zero
    assign wbs_readdata = period_rd | width_rd | ctrl_rd | status_rd | count_rd;

    // status never shows a running pulse train and a rejected setup together
    a_status_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(busy && cfg_error)
    );

endmodule

// File: pulse_cfg_if.sv
`timescale 1ns/100ps

// configuration path from the register block to the sequencer and output stage
interface pulse_cfg_if #(
    parameter int CNT_WIDTH = 24
);

    // timing in clock cycles
    logic [CNT_WIDTH-1:0]    period;
    logic [CNT_WIDTH-1:0]    width;

    // control word fields
    pulse_pkg::pulse_mode_t  mode;
    logic                    polarity;
    pulse_pkg::burst_len_t   burst_len;

    // one cycle after a control write is stored;
    // restarts the sequencer from SEQ_IDLE or any running seq_state_t phase
    logic                    ctrl_write;

    modport regs (
        output period, width, mode, polarity, burst_len, ctrl_write
    );

    modport seq (
        input period, width, mode, burst_len, ctrl_write
    );

    // only the polarity is needed at the pin
    modport out (
        input polarity
    );

endinterface

// File: pulse_gen_patterns.txt
# cmd name args in hex: W addr data | R addr expected | Q idle_level cycles
# M polarity high_cycles low_cycles pulses done_expected
R reset_period 00 00000000
R reset_width 01 00000000
R reset_ctrl 02 00000000
R reset_status 03 00000000
R reset_count 04 00000000
W wr_period 00 AB123456
R rd_period 00 00123456
W wr_width 01 FFFFFFFF
R rd_width 01 00FFFFFF
W wr_ctrl 02 FFFFABFC
R rd_ctrl 02 0000AB04
R rd_unmapped 0107 00000000
# single mode
W single_period 00 0000000A
W single_width 01 00000003
W single_ctrl 02 00000001
M single_pulse 0 3 7 1 1
R single_count 04 00000001
R single_status 03 00000000
# burst of four, inverted
W burst_ctrl 02 00000406
M burst_pulse 1 3 7 4 1
R burst_count 04 00000004
R burst_status 03 00000000
# continuous, stopped by mode off
W cont_period 00 00000008
W cont_width 01 00000002
W cont_ctrl 02 00000003
M cont_pulse 0 2 6 5 0
W cont_off 02 00000000
R cont_status 03 00000000
Q cont_quiet 0 20
# invalid configurations, then recovery
W zero_width 01 00000000
W zero_ctrl 02 00000001
R zero_status 03 00000002
Q zero_quiet 0 20
W equal_width 01 00000008
W equal_ctrl 02 00000001
R equal_status 03 00000002
Q equal_quiet 0 20
W valid_period 00 00000006
W valid_width 01 00000002
W valid_ctrl 02 00000001
M valid_pulse 0 2 4 1 1
R valid_status 03 00000000
R valid_count 04 00000001

// File: pulse_gen_tb.sv
`timescale 1ns/100ps

module pulse_gen_tb;

    localparam int ADDR_WIDTH = 16;
    localparam int CNT_WIDTH  = 24;
    // longest any single wait may run, in cycles
    localparam int TIMEOUT    = 2000;

    logic                  clk;
    logic                  reset;
    logic [ADDR_WIDTH-1:0] wbs_address;
    pulse_pkg::wb_data_t   wbs_writedata;
    pulse_pkg::wb_data_t   wbs_readdata;
    logic                  wbs_strobe;
    logic                  wbs_cycle;
    logic                  wbs_write;
    logic                  wbs_ack;
    logic                  pulse_out;
    logic                  done;

    pulse_gen_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) pulse_gen_top_inst (
        .clk           (clk),
        .reset         (reset),
        .wbs_address   (wbs_address),
        .wbs_writedata (wbs_writedata),
        .wbs_readdata  (wbs_readdata),
        .wbs_strobe    (wbs_strobe),
        .wbs_cycle     (wbs_cycle),
        .wbs_write     (wbs_write),
        .wbs_ack       (wbs_ack),
        .pulse_out     (pulse_out),
        .done          (done)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input pulse_pkg::wb_data_t exp,
                              input pulse_pkg::wb_data_t act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_cycles(input string name, input logic [CNT_WIDTH-1:0] exp,
                                input logic [CNT_WIDTH-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
        end
    endtask

    // ------------------------------------------------------------
    // wishbone master
    // ------------------------------------------------------------
    task automatic bus_access(input string name, input logic is_write,
                              input logic [ADDR_WIDTH-1:0] addr,
                              input pulse_pkg::wb_data_t wdata,
                              output pulse_pkg::wb_data_t rdata);
        int waited;
        waited = 0;
        // at least one idle cycle, then a random gap
        @(negedge clk);
        repeat ($urandom % 4) @(negedge clk);
        wbs_address   = addr;
        wbs_writedata = wdata;
        wbs_write     = is_write;
        wbs_strobe    = 1'b1;
        wbs_cycle     = 1'b1;
        @(negedge clk);
        // hold the request until ack
        while (!wbs_ack) begin
            if (waited == TIMEOUT) begin
                fail_run($sformatf("%s: no bus acknowledge within %0d cycles", name, TIMEOUT));
            end
            waited++;
            @(negedge clk);
        end
        // ack follows the first edge of the access
        check_cycles({name, "_ack_wait"}, '0, CNT_WIDTH'(waited));
        // read data valid in the ack cycle
        rdata         = wbs_readdata;
        wbs_strobe    = 1'b0;
        wbs_cycle     = 1'b0;
        wbs_write     = 1'b0;
        wbs_writedata = '0;
    endtask

    // ------------------------------------------------------------
    // pin measurement
    // ------------------------------------------------------------
    task automatic measure_pulses(input string name, input logic pol,
                                  input logic [CNT_WIDTH-1:0] high_exp,
                                  input logic [CNT_WIDTH-1:0] low_exp,
                                  input int pulses, input logic done_exp);
        logic active;
        int   waited;
        int   high_cnt;
        int   low_cnt;
        active = ~pol;
        waited = 0;
        // a polarity change leaves one stale cycle, so start from idle
        while (pulse_out !== pol) begin
            if (waited == TIMEOUT) begin
                fail_run($sformatf("%s: pin never settled to its idle level", name));
            end
            waited++;
            @(negedge clk);
        end
        for (int i = 0; i < pulses; i++) begin
            waited = 0;
            while (pulse_out !== active) begin
                check_level({name, "_early_done"}, 1'b0, done);
                if (waited == TIMEOUT) begin
                    fail_run($sformatf("%s: pulse %0d never started", name, i + 1));
                end
                waited++;
                @(negedge clk);
            end
            high_cnt = 0;
            while (pulse_out === active) begin
                check_level({name, "_done_in_high"}, 1'b0, done);
                if (high_cnt == TIMEOUT) begin
                    fail_run($sformatf("%s: pulse %0d stuck at its active level", name, i + 1));
                end
                high_cnt++;
                @(negedge clk);
            end
            check_cycles({name, "_high"}, high_exp, CNT_WIDTH'(high_cnt));
            // low phase ends at the next pulse or at done
            low_cnt = 0;
            while (pulse_out !== active && !done) begin
                if (low_cnt == TIMEOUT) begin
                    fail_run($sformatf("%s: low phase of pulse %0d never ended", name, i + 1));
                end
                low_cnt++;
                @(negedge clk);
            end
            check_cycles({name, "_low"}, low_exp, CNT_WIDTH'(low_cnt));
            check_level({name, "_done"}, done_exp && (i == pulses - 1), done);
        end
        if (done_exp) begin
            // done lasts one cycle only
            @(negedge clk);
            check_level({name, "_done_once"}, 1'b0, done);
        end
    endtask

    // pin idle and no done for a fixed window
    task automatic check_quiet(input string name, input logic pol, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            check_level({name, "_pin"}, pol, pulse_out);
            check_level({name, "_done"}, 1'b0, done);
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int                  fd;
        int                  code;
        string               line;
        string               cmd;
        string               name;
        logic [31:0]         a0, a1, a2, a3, a4;
        pulse_pkg::wb_data_t rdata;

        clk           = 1'b0;
        reset         = 1'b1;
        wbs_address   = '0;
        wbs_writedata = '0;
        wbs_strobe    = 1'b0;
        wbs_cycle     = 1'b0;
        wbs_write     = 1'b0;
        a0 = '0;
        a1 = '0;
        a2 = '0;
        a3 = '0;
        a4 = '0;
        void'($urandom(32'h553fb239));

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("pulse_gen_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("could not open pulse_gen_patterns.txt for reading");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // skip blank and comment lines
            if (code == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%s %s %h %h %h %h %h", cmd, name, a0, a1, a2, a3, a4);
            if (cmd == "W") begin
                bus_access(name, 1'b1, a0[ADDR_WIDTH-1:0], a1, rdata);
            end else if (cmd == "R") begin
                bus_access(name, 1'b0, a0[ADDR_WIDTH-1:0], '0, rdata);
                check_word(name, a1, rdata);
            end else if (cmd == "M") begin
                measure_pulses(name, a0[0], a1[CNT_WIDTH-1:0], a2[CNT_WIDTH-1:0],
                               int'(a3), a4[0]);
            end else if (cmd == "Q") begin
                check_quiet(name, a0[0], int'(a1));
            end else begin
                fail_run({"unknown command in the patterns file: ", cmd});
            end
        end
        $fclose(fd);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: pulse_gen_top.sv
`timescale 1ns/100ps

module pulse_gen_top #(
    parameter int ADDR_WIDTH = 16,
    // counter width, 8 to 32
    parameter int CNT_WIDTH  = 24
) (
    input  logic                  clk,
    input  logic                  reset,

    // wishbone slave
    input  logic [ADDR_WIDTH-1:0] wbs_address,
    input  pulse_pkg::wb_data_t   wbs_writedata,
    output pulse_pkg::wb_data_t   wbs_readdata,
    input  logic                  wbs_strobe,
    input  logic                  wbs_cycle,
    input  logic                  wbs_write,
    output logic                  wbs_ack,

    // generator outputs
    output logic                  pulse_out,
    output logic                  done
);

    // ------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------
    pulse_cfg_if #(.CNT_WIDTH(CNT_WIDTH)) cfg_if ();

    logic                 busy;
    logic                 cfg_error;
    logic                 cfg_write_ok;
    logic                 raw_level;
    logic                 pulse_start;
    logic                 run_end;
    logic [CNT_WIDTH-1:0] pulse_count;

    // decode
    gen_pulse_reg #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) gen_pulse_reg_inst (
        .clk           (clk),
        .reset         (reset),
        .wbs_address   (wbs_address),
        .wbs_writedata (wbs_writedata),
        .wbs_readdata  (wbs_readdata),
        .wbs_strobe    (wbs_strobe),
        .wbs_cycle     (wbs_cycle),
        .wbs_write     (wbs_write),
        .wbs_ack       (wbs_ack),
        .busy          (busy),
        .cfg_error     (cfg_error),
        .pulse_count   (pulse_count),
        .cfg           (cfg_if.regs)
    );

    // execute
    pulse_sequencer #(
        .CNT_WIDTH (CNT_WIDTH)
    ) pulse_sequencer_inst (
        .clk          (clk),
        .reset        (reset),
        .cfg          (cfg_if.seq),
        .raw_level    (raw_level),
        .pulse_start  (pulse_start),
        .run_end      (run_end),
        .busy         (busy),
        .cfg_error    (cfg_error),
        .cfg_write_ok (cfg_write_ok)
    );

    // result
    pulse_output #(
        .CNT_WIDTH (CNT_WIDTH)
    ) pulse_output_inst (
        .clk          (clk),
        .reset        (reset),
        .raw_level    (raw_level),
        .pulse_start  (pulse_start),
        .run_end      (run_end),
        .cfg_write_ok (cfg_write_ok),
        .cfg          (cfg_if.out),
        .pulse_out    (pulse_out),
        .done         (done),
        .pulse_count  (pulse_count)
    );

endmodule

// File: pulse_output.sv
`timescale 1ns/100ps

module pulse_output #(
    parameter int CNT_WIDTH = 24
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 raw_level,
    input  logic                 pulse_start,
    input  logic                 run_end,
    input  logic                 cfg_write_ok,
    pulse_cfg_if.out             cfg,
    output logic                 pulse_out,
    output logic                 done,
    output logic [CNT_WIDTH-1:0] pulse_count
);

    // ------------------------------------------------------------
    // pin and completion flag
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pulse_out <= 1'b0;
            done      <= 1'b0;
        end else begin
            // flop straight to the pin, no decode glitches
            pulse_out <= raw_level ^ cfg.polarity;
            done      <= run_end;
        end
    end

    // ------------------------------------------------------------
    // pulse counter
    // ------------------------------------------------------------
    logic count_full;

    assign count_full = &pulse_count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pulse_count <= '0;
        end else if (cfg_write_ok) begin
            // new run, fresh count
            pulse_count <= '0;
        end else if (pulse_start && !count_full) begin
            // saturates at all ones
            pulse_count <= pulse_count + 1'b1;
        end
    end

    // run end is a single strobe upstream, so done never stretches
    a_done_single: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done
    );

endmodule

// File: pulse_pkg.sv
package pulse_pkg;

    // ------------------------------------------------------------
    // bus word
    // ------------------------------------------------------------
    typedef logic [31:0] wb_data_t;

    // 8-bit burst count, 0 runs as a single period
    typedef logic [7:0] burst_len_t;

    // ------------------------------------------------------------
    // enums
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        MODE_OFF        = 2'd0,
        MODE_SINGLE     = 2'd1,
        MODE_BURST      = 2'd2,
        MODE_CONTINUOUS = 2'd3
    } pulse_mode_t;

    // sequencer phases, code 3 unused
    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_HIGH = 2'd1,
        SEQ_LOW  = 2'd2
    } seq_state_t;

    // ------------------------------------------------------------
    // register map, low 8 address bits
    // ------------------------------------------------------------
    localparam logic [7:0] REG_PERIOD_ADDR = 8'h00;
    localparam logic [7:0] REG_WIDTH_ADDR  = 8'h01;
    localparam logic [7:0] REG_CTRL_ADDR   = 8'h02;
    localparam logic [7:0] REG_STATUS_ADDR = 8'h03;
    localparam logic [7:0] REG_COUNT_ADDR  = 8'h04;

    // control word fields
    localparam int CTRL_MODE_LSB  = 0;
    localparam int CTRL_MODE_MSB  = 1;
    localparam int CTRL_POL_BIT   = 2;
    localparam int CTRL_BURST_LSB = 8;
    localparam int CTRL_BURST_MSB = 15;

    // status word bits
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_ERR_BIT  = 1;

endpackage

// File: pulse_sequencer.sv
`timescale 1ns/100ps

module pulse_sequencer #(
    parameter int CNT_WIDTH = 24
) (
    input  logic       clk,
    input  logic       reset,
    pulse_cfg_if.seq   cfg,
    output logic       raw_level,
    output logic       pulse_start,
    output logic       run_end,
    output logic       busy,
    output logic       cfg_error,
    output logic       cfg_write_ok
);

    pulse_pkg::seq_state_t  state;
    pulse_pkg::pulse_mode_t mode_q;
    pulse_pkg::burst_len_t  rem;
    logic [CNT_WIDTH-1:0]   cnt;
    logic [CNT_WIDTH-1:0]   wid_q;
    logic [CNT_WIDTH-1:0]   low_q;
    logic                   cfg_valid;
    logic                   high_last;
    logic                   low_last;
    logic                   last_period;

    // ------------------------------------------------------------
    // configuration check and phase ends
    // ------------------------------------------------------------
    // width must be nonzero and leave at least one low cycle
    assign cfg_valid    = (cfg.width != '0) && (cfg.width < cfg.period);
    // accepted run, one cycle ahead of the first high cycle
    assign cfg_write_ok = cfg.ctrl_write && cfg_valid && (cfg.mode != pulse_pkg::MODE_OFF);

    assign high_last   = (cnt == wid_q - 1'b1);
    assign low_last    = (cnt == low_q - 1'b1);
    // continuous never ends on its own
    assign last_period = (mode_q != pulse_pkg::MODE_CONTINUOUS) && (rem == 8'd1);

    // timing captured at start, later register writes do not disturb a run
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wid_q <= '0;
            low_q <= '0;
        end else if (cfg_write_ok) begin
            wid_q <= cfg.width;
            low_q <= cfg.period - cfg.width;
        end
    end

    // ------------------------------------------------------------
    // FSM and counters
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= pulse_pkg::SEQ_IDLE;
            mode_q    <= pulse_pkg::MODE_OFF;
            rem       <= '0;
            cnt       <= '0;
            busy      <= 1'b0;
            cfg_error <= 1'b0;
            run_end   <= 1'b0;
        end else begin
            run_end <= 1'b0;
            if (cfg.ctrl_write) begin
                // any control write restarts from the first cycle
                cnt <= '0;
                if (cfg.mode == pulse_pkg::MODE_OFF) begin
                    state <= pulse_pkg::SEQ_IDLE;
                    busy  <= 1'b0;
                end else if (!cfg_valid) begin
                    state     <= pulse_pkg::SEQ_IDLE;
                    busy      <= 1'b0;
                    cfg_error <= 1'b1;
                end else begin
                    state     <= pulse_pkg::SEQ_HIGH;
                    busy      <= 1'b1;
                    cfg_error <= 1'b0;
                    mode_q    <= cfg.mode;
                    // burst of 0 runs once
                    if (cfg.mode == pulse_pkg::MODE_BURST && cfg.burst_len != '0) begin
                        rem <= cfg.burst_len;
                    end else begin
                        rem <= 8'd1;
                    end
                end
            end else begin
                case (state)
                    pulse_pkg::SEQ_HIGH: begin
                        if (high_last) begin
                            state <= pulse_pkg::SEQ_LOW;
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    pulse_pkg::SEQ_LOW: begin
                        if (low_last) begin
                            cnt <= '0;
                            if (last_period) begin
                                state   <= pulse_pkg::SEQ_IDLE;
                                busy    <= 1'b0;
                                run_end <= 1'b1;
                            end else begin
                                state <= pulse_pkg::SEQ_HIGH;
                                // period count only matters outside continuous
                                if (mode_q != pulse_pkg::MODE_CONTINUOUS) begin
                                    rem <= rem - 1'b1;
                                end
                            end
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    pulse_pkg::SEQ_IDLE: begin
                        cnt <= '0;
                    end
                    default: begin
                        // unused code, recover to idle
                        state <= pulse_pkg::SEQ_IDLE;
                        busy  <= 1'b0;
                        cnt   <= '0;
                    end
                endcase
            end
        end
    end

    assign raw_level   = (state == pulse_pkg::SEQ_HIGH);
    assign pulse_start = raw_level && (cnt == '0);

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // pin only active during a run
    a_level_busy: assert property (
        @(posedge clk) disable iff (reset)
        raw_level |-> busy
    );

    a_idle_not_busy: assert property (
        @(posedge clk) disable iff (reset)
        (state == pulse_pkg::SEQ_IDLE) |-> !busy
    );

    // entered from another phase, or restarted by an accepted write
    a_start_first: assert property (
        @(posedge clk) disable iff (reset)
        pulse_start |-> ($past(state) != pulse_pkg::SEQ_HIGH || $past(cfg_write_ok))
    );

endmodule
